// ==== bench/snake_asserts.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_asserts (
    input logic             clk25,
    input logic             rst_n,
    input logic             step,
    input logic             restart,
    input snake_pkg::rgb_t  rgb,
    input snake_pkg::cell_t head,
    input snake_pkg::cell_t apple,
    input logic [6:0]       score
);

    // sampled mid-cycle, the first rising edge has cleared the colour by then
    a_rgb_reset: assert property (@(negedge clk25) !rst_n |-> rgb == `RGB_OFF)
        else $error("rgb is not black while reset is low");

    a_score_max: assert property (@(posedge clk25) disable iff (!rst_n)
        score <= 7'(`SNAKE_MAX - `INIT_LEN))
        else $error("score is above the segment limit");

    // head and apple only move on a step or a restart
    a_hold: assert property (@(posedge clk25) disable iff (!rst_n)
        (!step && !restart) |=> ($stable(head) && $stable(apple)))
        else $error("head or apple changed without a step or a restart");

endmodule

bind snake_top snake_asserts i_snake_asserts (
    .clk25   (clk25),
    .rst_n   (rst_n),
    .step    (step),
    .restart (restart),
    .rgb     (rgb),
    .head    (head),
    .apple   (apple),
    .score   (score)
);

// ==== bench/snake_tb.sv ====
`timescale 1ns/1ps

module snake_tb;
    import snake_pkg::*;

    localparam int OP_KEY   = 0;
    localparam int OP_STEP  = 1;
    localparam int OP_HEAD  = 2;
    localparam int OP_APPLE = 3;
    localparam int OP_SCORE = 4;
    localparam int OP_DEAD  = 5;
    localparam int OP_PIXEL = 6;

    logic       clk25;
    logic       rst_n;
    logic       key_strobe;
    logic [7:0] key_code;
    logic       step;
    pixel_t     pix;
    rgb_t       rgb;
    cell_t      head;
    cell_t      apple;
    logic [6:0] score;
    logic       dead;

    // one entry per vector command
    int op_q[$];
    int arg_a_q[$];
    int arg_b_q[$];
    int arg_c_q[$];
    int errors      = 0;
    int step_cycles = 0;
    int cycle_count = 0;
    int cycle_limit = 0;

    snake_top i_snake_top (
        .clk25      (clk25),
        .rst_n      (rst_n),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .step       (step),
        .pix        (pix),
        .rgb        (rgb),
        .head       (head),
        .apple      (apple),
        .score      (score),
        .dead       (dead)
    );

    initial begin
        clk25 = 1'b0;
        forever #2 clk25 = ~clk25;
    end

    task automatic add_command(input int op, input int a, input int b, input int c);
        op_q.push_back(op);
        arg_a_q.push_back(a);
        arg_b_q.push_back(b);
        arg_c_q.push_back(c);
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        int a;
        int b;
        int c;
        logic [63:0]   word;
        logic [63:0]   what;
        logic [1023:0] rest;
        fd = $fopen("bench/snake_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open bench/snake_vectors.txt");
            return;
        end
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == 64'("#")) begin
                n = $fgets(rest, fd);  // rest of a comment line
            end else if (word == 64'("key")) begin
                n = $fscanf(fd, "%h", a);
                add_command(OP_KEY, a, 0, 0);
            end else if (word == 64'("step")) begin
                n = $fscanf(fd, "%d", a);
                step_cycles += 4 * a;  // pulse plus three idle cycles
                add_command(OP_STEP, a, 0, 0);
            end else if (word == 64'("pixel")) begin
                n = $fscanf(fd, "%d %d %h", a, b, c);
                add_command(OP_PIXEL, a, b, c);
            end else if (word == 64'("expect")) begin
                n = $fscanf(fd, "%s %d", what, a);
                if (what == 64'("head")) begin
                    n = $fscanf(fd, "%d", b);
                    add_command(OP_HEAD, a, b, 0);
                end else if (what == 64'("apple")) begin
                    n = $fscanf(fd, "%d", b);
                    add_command(OP_APPLE, a, b, 0);
                end else if (what == 64'("score")) begin
                    add_command(OP_SCORE, a, 0, 0);
                end else if (what == 64'("dead")) begin
                    add_command(OP_DEAD, a, 0, 0);
                end else begin
                    errors++;
                    $display("vector file expects an unknown signal");
                end
            end else begin
                errors++;
                $display("vector file holds an unknown command");
                n = $fgets(rest, fd);
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            errors++;
            $display("vector file holds no commands");
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAIL %s expected %0h got %0h at cycle %0d", name, expected, actual,
                 cycle_count);
    endtask

    // each command starts and ends on a falling edge
    task automatic run_command(input int op, input int a, input int b, input int c);
        case (op)
            OP_KEY: begin
                key_strobe = 1'b1;
                key_code   = 8'(a);
                @(negedge clk25);
                key_strobe = 1'b0;
                key_code   = 8'h00;
                repeat (3) @(negedge clk25);  // turn register, then direction
            end
            OP_STEP: begin
                repeat (a) begin
                    step = 1'b1;
                    @(negedge clk25);
                    step = 1'b0;
                    repeat (3) @(negedge clk25);
                end
            end
            OP_HEAD: begin
                if (head.x !== 7'(a)) begin
                    report_mismatch("head.x", 32'(a), 32'(head.x));
                end
                if (head.y !== 6'(b)) begin
                    report_mismatch("head.y", 32'(b), 32'(head.y));
                end
            end
            OP_APPLE: begin
                if (apple.x !== 7'(a)) begin
                    report_mismatch("apple.x", 32'(a), 32'(apple.x));
                end
                if (apple.y !== 6'(b)) begin
                    report_mismatch("apple.y", 32'(b), 32'(apple.y));
                end
            end
            OP_SCORE: begin
                if (score !== 7'(a)) begin
                    report_mismatch("score", 32'(a), 32'(score));
                end
            end
            OP_DEAD: begin
                if (dead !== 1'(a)) begin
                    report_mismatch("dead", 32'(a), 32'(dead));
                end
            end
            OP_PIXEL: begin
                pix.px = 10'(a);
                pix.py = 10'(b);
                @(negedge clk25);  // colour is registered
                if (rgb !== 12'(c)) begin
                    report_mismatch("rgb", 32'(c), 32'(rgb));
                end
            end
            default: begin
                errors++;
                $display("vector command code %0d is not known", op);
            end
        endcase
    endtask

    always @(posedge clk25) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: vectors not finished after %0d cycles", cycle_count);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst_n      = 1'b0;
        key_strobe = 1'b0;
        key_code   = 8'h00;
        step       = 1'b0;
        pix        = '0;
        load_vectors();
        cycle_limit = 4 * step_cycles + 200;
        repeat (16) @(posedge clk25);
        @(negedge clk25);
        rst_n = 1'b1;
        foreach (op_q[i]) begin
            run_command(op_q[i], arg_a_q[i], arg_b_q[i], arg_c_q[i]);
        end
        @(negedge clk25);
        $display("%0d errors in %0d vector commands", errors, op_q.size());
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/snake_vectors.txt ====
# key <scan code hex> | step <count> | pixel <px> <py> <rgb hex>
# expect head|apple <x> <y> | expect score|dead <value>, numbers decimal
expect head 3 0
expect apple 6 0
expect score 0
expect dead 0
pixel 35 5 00F
pixel 65 5 0F0
pixel 300 300 FFF
# three steps reach the apple, the fourth eats it
step 3
expect head 6 0
step 1
expect head 7 0
expect score 1
expect apple 3 3
pixel 35 5 00F
pixel 25 5 FFF
pixel 35 35 0F0
# down, left, a refused right, then up
key 72
step 2
expect head 7 2
key 6B
step 2
expect head 5 2
key 74
step 1
expect head 4 2
key 75
step 1
expect head 4 1
# off the top wall, then frozen
step 2
expect dead 1
expect head 4 63
step 3
expect head 4 63
expect score 1
# restart, then a key that means nothing
key 29
expect dead 0
expect head 3 0
expect apple 6 0
expect score 0
pixel 45 15 FFF
key 1C
step 4
expect head 7 0
expect apple 3 3
pixel 650 10 000

// ==== filelist.f ====
+incdir+src
src/snake_pkg.sv
src/key_decode.sv
src/snake_execute.sv
src/pixel_result.sv
src/snake_top.sv
bench/snake_asserts.sv
bench/snake_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the snake testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module snake_tb \
    -f filelist.f -Mdir "$build_dir" -o snake_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/snake_sim" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$log"; then
    echo "testbench reported failure"
    exit 1
fi
if ! grep -q "RESULT: PASS" "$log"; then
    echo "no verdict found in $log"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== src/key_decode.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module key_decode (
    input  logic             clk25,
    input  logic             rst_n,
    input  logic             key_strobe,
    input  logic [7:0]       key_code,
    output snake_pkg::turn_t turn,
    output logic             restart
);
    import snake_pkg::*;

    logic is_arrow;
    logic is_restart;
    dir_t key_dir;

    always_comb begin
        is_arrow = 1'b1;
        key_dir  = DIR_UP;
        case (key_code)
            `KEY_UP:    key_dir = DIR_UP;
            `KEY_DOWN:  key_dir = DIR_DOWN;
            `KEY_LEFT:  key_dir = DIR_LEFT;
            `KEY_RIGHT: key_dir = DIR_RIGHT;
            default:    is_arrow = 1'b0;
        endcase
    end

    assign is_restart = (key_code == `KEY_RESTART);

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            turn    <= '{valid: 1'b0, dir: DIR_RIGHT};
            restart <= 1'b0;
        end else begin
            restart <= key_strobe && is_restart;  // one cycle pulse
            if (key_strobe && is_arrow) begin
                turn <= '{valid: 1'b1, dir: key_dir};
            end else if (key_strobe && is_restart) begin
                // an old turn would bend the fresh snake right after restart
                turn.valid <= 1'b0;
            end
        end
    end

endmodule

// ==== src/pixel_result.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module pixel_result (
    input  logic              clk25,
    input  logic              rst_n,
    input  snake_pkg::pixel_t pix,
    input  snake_pkg::cell_t  body [`SNAKE_MAX],
    input  logic [4:0]        length,
    input  snake_pkg::cell_t  apple,
    output snake_pkg::rgb_t   rgb
);
    import snake_pkg::*;

    cell_t pix_cell;
    logic  on_board;
    logic  hit_snake;
    logic  hit_apple;
    rgb_t  rgb_nxt;

    // constant divide, cell index of the pixel
    always_comb begin
        pix_cell.x = 7'(pix.px / 10'(`CELL_PX));
        pix_cell.y = 6'(pix.py / 10'(`CELL_PX));
    end

    assign on_board = (pix.px < 10'(`BOARD_W * `CELL_PX))
                   && (pix.py < 10'(`BOARD_H * `CELL_PX));

    always_comb begin
        hit_snake = 1'b0;
        for (int i = 0; i < `SNAKE_MAX; i++) begin
            if (i < int'(length) && body[i] == pix_cell) begin
                hit_snake = 1'b1;
            end
        end
    end

    assign hit_apple = (pix_cell == apple);

    always_comb begin
        if (!on_board) begin
            rgb_nxt = `RGB_OFF;
        end else if (hit_snake) begin
            rgb_nxt = `RGB_SNAKE;  // snake drawn over apple
        end else if (hit_apple) begin
            rgb_nxt = `RGB_APPLE;
        end else begin
            rgb_nxt = `RGB_BG;
        end
    end

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            rgb <= `RGB_OFF;
        end else begin
            rgb <= rgb_nxt;
        end
    end

endmodule

// ==== src/snake_config.svh ====
`ifndef SNAKE_CONFIG_SVH
`define SNAKE_CONFIG_SVH

// board geometry, in cells and pixels
`define BOARD_W     64
`define BOARD_H     48
`define CELL_PX     10

`define SNAKE_MAX   16
`define INIT_LEN    4
`define PARK_X      64    // unused segments sit off the board
`define PARK_Y      50
`define APPLE_X0    6
`define APPLE_Y0    0

// keyboard scan codes
`define KEY_UP      8'h75
`define KEY_DOWN    8'h72
`define KEY_LEFT    8'h6B
`define KEY_RIGHT   8'h74
`define KEY_RESTART 8'h29

`define RGB_BG      12'hFFF
`define RGB_SNAKE   12'h00F
`define RGB_APPLE   12'h0F0
`define RGB_OFF     12'h000

`endif

// ==== src/snake_execute.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_execute (
    input  logic             clk25,
    input  logic             rst_n,
    input  logic             step,
    input  snake_pkg::turn_t turn,
    input  logic             restart,
    output snake_pkg::cell_t body [`SNAKE_MAX],
    output snake_pkg::cell_t apple,
    output logic [4:0]       length,
    output logic [6:0]       score,
    output logic             dead
);
    import snake_pkg::*;

    dir_t       dir;         // applied at the next step
    dir_t       last_dir;    // direction of the last move
    logic [5:0] step_mod_x;  // step_count mod 63
    logic [5:0] step_mod_y;  // step_count mod 47
    cell_t      head_nxt;
    logic       eat;
    logic       grow;
    logic       turn_ok;
    logic [4:0] len_nxt;

    // starting layout: head at (3,0) trailing left, rest parked
    function automatic cell_t start_cell(input int idx);
        cell_t c;
        if (idx < `INIT_LEN) begin
            c.x = 7'(`INIT_LEN - 1 - idx);
            c.y = 6'd0;
        end else begin
            c.x = 7'(`PARK_X);
            c.y = 6'(`PARK_Y);
        end
        return c;
    endfunction

    // wall hit or head on its own body
    always_comb begin
        dead = (body[0].x >= 7'(`BOARD_W)) || (body[0].y >= 6'(`BOARD_H));
        for (int i = 1; i < `SNAKE_MAX; i++) begin
            if (i < int'(length) && body[i] == body[0]) begin
                dead = 1'b1;
            end
        end
    end

    // off-board moves wrap into x >= 64 or y >= 48 and so read as dead
    always_comb begin
        head_nxt = body[0];
        case (dir)
            DIR_UP:   head_nxt.y = body[0].y - 6'd1;
            DIR_DOWN: head_nxt.y = body[0].y + 6'd1;
            DIR_LEFT: head_nxt.x = body[0].x - 7'd1;
            default:  head_nxt.x = body[0].x + 7'd1;
        endcase
    end

    assign eat     = (body[0] == apple);
    assign grow    = eat && (length < 5'(`SNAKE_MAX));
    assign len_nxt = grow ? length + 5'd1 : length;
    assign turn_ok = turn.valid && (turn.dir[1] != last_dir[1]);  // perpendicular only
    assign score   = 7'(length - 5'(`INIT_LEN));

    always_ff @(posedge clk25 or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SNAKE_MAX; i++) begin
                body[i] <= start_cell(i);
            end
            length     <= 5'(`INIT_LEN);
            dir        <= DIR_RIGHT;
            last_dir   <= DIR_RIGHT;
            apple      <= '{y: 6'(`APPLE_Y0), x: 7'(`APPLE_X0)};
            step_mod_x <= '0;
            step_mod_y <= '0;
        end else if (restart) begin
            for (int i = 0; i < `SNAKE_MAX; i++) begin
                body[i] <= start_cell(i);
            end
            length     <= 5'(`INIT_LEN);
            dir        <= DIR_RIGHT;
            last_dir   <= DIR_RIGHT;
            apple      <= '{y: 6'(`APPLE_Y0), x: 7'(`APPLE_X0)};
            step_mod_x <= '0;
            step_mod_y <= '0;
        end else begin
            if (turn_ok) begin
                dir <= turn.dir;
            end
            if (step) begin
                // step count advances even while dead
                step_mod_x <= (step_mod_x == 6'(`BOARD_W - 2)) ? 6'd0 : step_mod_x + 6'd1;
                step_mod_y <= (step_mod_y == 6'(`BOARD_H - 2)) ? 6'd0 : step_mod_y + 6'd1;
                if (!dead) begin
                    // on growth the old tail is copied one slot further and stays put
                    for (int i = 1; i < `SNAKE_MAX; i++) begin
                        if (i < int'(len_nxt)) begin
                            body[i] <= body[i-1];
                        end
                    end
                    body[0]  <= head_nxt;
                    last_dir <= dir;
                    length   <= len_nxt;
                    if (eat) begin
                        apple <= '{y: step_mod_y, x: {1'b0, step_mod_x}};
                    end
                end
            end
        end
    end

endmodule

// ==== src/snake_pkg.sv ====
package snake_pkg;

    // y above x, matches the packed cell word used across the design
    typedef struct packed {
        logic [5:0] y;
        logic [6:0] x;
    } cell_t;

    // bit 1 separates vertical from horizontal moves
    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_t;

    typedef struct packed {
        logic [9:0] px;
        logic [9:0] py;
    } pixel_t;

    typedef logic [11:0] rgb_t;  // 4 bits each of r, g, b

    typedef struct packed {
        logic valid;
        dir_t dir;
    } turn_t;

endpackage

// ==== src/snake_top.sv ====
`timescale 1ns/1ps
`include "snake_config.svh"

module snake_top (
    input  logic              clk25,
    input  logic              rst_n,
    input  logic              key_strobe,
    input  logic [7:0]        key_code,
    input  logic              step,
    input  snake_pkg::pixel_t pix,
    output snake_pkg::rgb_t   rgb,
    output snake_pkg::cell_t  head,
    output snake_pkg::cell_t  apple,
    output logic [6:0]        score,
    output logic              dead
);
    import snake_pkg::*;

    turn_t      turn;
    logic       restart;
    cell_t      body [`SNAKE_MAX];
    logic [4:0] length;  // live segment count

    key_decode i_key_decode (
        .clk25      (clk25),
        .rst_n      (rst_n),
        .key_strobe (key_strobe),
        .key_code   (key_code),
        .turn       (turn),
        .restart    (restart)
    );

    snake_execute i_snake_execute (
        .clk25   (clk25),
        .rst_n   (rst_n),
        .step    (step),
        .turn    (turn),
        .restart (restart),
        .body    (body),
        .apple   (apple),
        .length  (length),
        .score   (score),
        .dead    (dead)
    );

    pixel_result i_pixel_result (
        .clk25  (clk25),
        .rst_n  (rst_n),
        .pix    (pix),
        .body   (body),
        .length (length),
        .apple  (apple),
        .rgb    (rgb)
    );

    assign head = body[0];

endmodule
